// File: common/vlsu_defines.svh
`ifndef VLSU_DEFINES_SVH
`define VLSU_DEFINES_SVH

// --------------------
// Datapath geometry
// --------------------
`define VLSU_NR_LANES     4
`define VLSU_LANE_BYTES   4
// Lanes times lane bytes
`define VLSU_ROW_BYTES    16
`define VLSU_BEAT_BYTES   8

// --------------------
// Queue and register file
// --------------------
`define VLSU_INFO_DEPTH   4
// 64-byte vector register, 16-byte rows
`define VLSU_ROWS_PER_REG 4
`define VLSU_REQ_ID_BITS  3
// 32 registers of 4 rows each
`define VLSU_SET_BITS     7

`endif

// File: common/vlsu_cfg_pkg.sv
`include "vlsu_defines.svh"

package vlsu_cfg_pkg;

  // Element width, log2 of element bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2
  } ew_e;

  // Strided only travels through the queue, handled like unit stride
  typedef enum logic [1:0] {
    UNIT    = 2'd0,
    STRIDED = 2'd1
  } ld_mode_e;

  // Sequential byte landing at lane byte position pos (lane * lane bytes + offset)
  function automatic int unsigned seq_byte_idx(input int unsigned pos, input ew_e ew);
    int unsigned lane;
    int unsigned off;
    int unsigned eb;
    int unsigned elem;
    lane = pos / `VLSU_LANE_BYTES;
    off  = pos % `VLSU_LANE_BYTES;
    eb   = 32'd1 << ew;
    // Slot within lane picks element group, lane picks element in group
    elem = (off / eb) * `VLSU_NR_LANES + lane;
    return elem * eb + off % eb;
  endfunction

endpackage

// File: common/vlsu_msg_pkg.sv
`include "vlsu_defines.svh"

package vlsu_msg_pkg;

  // --------------------
  // Instruction metadata
  // --------------------
  typedef struct packed {
    logic [`VLSU_REQ_ID_BITS-1:0] req_id;
    vlsu_cfg_pkg::ld_mode_e       mode;
    vlsu_cfg_pkg::ew_e            ew;
    logic [4:0]                   vd;
    // Set means unmasked
    logic                         vm;
    // Rows minus one
    logic [3:0]                   row_cnt;
  } ld_meta_t;

  // Queued entry, metadata plus current target set
  typedef struct packed {
    ld_meta_t                   meta;
    logic [`VLSU_SET_BITS-1:0]  vaddr_set;
  } shf_info_t;

  // --------------------
  // Per-lane write
  // --------------------
  typedef struct packed {
    logic [`VLSU_REQ_ID_BITS-1:0]  req_id;
    logic [`VLSU_SET_BITS-1:0]     vaddr_set;
    logic [`VLSU_LANE_BYTES*8-1:0] data;
    logic [`VLSU_LANE_BYTES-1:0]   be;
  } lane_tx_t;

endpackage

// File: common/seq_row_if.sv
`timescale 1ns/1ps
`include "vlsu_defines.svh"

// One sequential row, packer to shuffler
interface seq_row_if;

  logic                          valid;
  logic                          ready;
  logic [`VLSU_ROW_BYTES*8-1:0]  data;
  // One enable per sequential byte
  logic [`VLSU_ROW_BYTES-1:0]    be;

  modport producer (
    output valid,
    output data,
    output be,
    input  ready
  );

  modport consumer (
    input  valid,
    input  data,
    input  be,
    output ready
  );

endinterface

// File: seq_load/seq_load.sv
`timescale 1ns/1ps
`include "vlsu_defines.svh"

module seq_load (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           beat_valid_i,
  output logic                           beat_ready_o,
  input  logic [`VLSU_BEAT_BYTES*8-1:0]  beat_data_i,
  input  logic [`VLSU_BEAT_BYTES-1:0]    beat_be_i,
  seq_row_if.producer                    row
);

  localparam int unsigned BeatBits = `VLSU_BEAT_BYTES * 8;

  // Row buffer
  logic [`VLSU_ROW_BYTES*8-1:0] row_data_q;
  logic [`VLSU_ROW_BYTES-1:0]   row_be_q;
  logic                         row_valid_q;
  // Which half the next beat fills
  logic                         half_q;

  logic beat_fire;
  logic row_fire;

  // Stall beats while a full row waits
  assign beat_ready_o = !row_valid_q;
  assign beat_fire    = beat_valid_i && beat_ready_o;
  assign row_fire     = row.valid && row.ready;

  // --------------------
  // Control
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      half_q      <= 1'b0;
      row_valid_q <= 1'b0;
    end else begin
      if (beat_fire) begin
        half_q <= !half_q;
        // High half done, row complete
        if (half_q) begin
          row_valid_q <= 1'b1;
        end
      end
      if (row_fire) begin
        row_valid_q <= 1'b0;
      end
    end
  end

  // --------------------
  // Payload
  // --------------------
  always_ff @(posedge clk_i) begin
    if (beat_fire) begin
      if (half_q) begin
        row_data_q[BeatBits +: BeatBits]                 <= beat_data_i;
        row_be_q[`VLSU_BEAT_BYTES +: `VLSU_BEAT_BYTES]   <= beat_be_i;
      end else begin
        row_data_q[0 +: BeatBits]                        <= beat_data_i;
        row_be_q[0 +: `VLSU_BEAT_BYTES]                  <= beat_be_i;
      end
    end
  end

  assign row.valid = row_valid_q;
  assign row.data  = row_data_q;
  assign row.be    = row_be_q;

endmodule

// File: logic/mask_unit.sv
`timescale 1ns/1ps
`include "vlsu_defines.svh"

module mask_unit (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          mask_load_i,
  input  vlsu_cfg_pkg::ew_e             mask_ew_i,
  input  logic [63:0]                   mask_bits_i,
  input  logic                          mrow_pop_i,
  output logic                          mrow_valid_o,
  output logic [`VLSU_ROW_BYTES-1:0]    mrow_strb_o
);

  logic [63:0]        mask_q;
  vlsu_cfg_pkg::ew_e  ew_q;
  logic [3:0]         row_q;
  logic               valid_q;

  logic [1:0]         ew_sh;
  logic [6:0]         elem_base;
  logic               last_row;

  assign ew_sh = ew_q;

  // First element of current row, row times 16/E
  assign elem_base = {3'b000, row_q} << (3'd4 - {1'b0, ew_sh});
  // 64 elements span 4, 8 or 16 rows
  assign last_row  = (row_q == ((4'd4 << ew_sh) - 4'd1));

  // --------------------
  // Strobe expansion
  // --------------------
  always_comb begin
    logic [6:0] idx;
    for (int b = 0; b < `VLSU_ROW_BYTES; b++) begin
      idx = elem_base + 7'(b >> ew_sh);
      mrow_strb_o[b] = mask_q[idx[5:0]];
    end
  end

  assign mrow_valid_o = valid_q;

  // Row pointer and validity
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ew_q    <= vlsu_cfg_pkg::EW8;
      row_q   <= '0;
      valid_q <= 1'b0;
    end else if (mask_load_i) begin
      ew_q    <= mask_ew_i;
      row_q   <= '0;
      valid_q <= 1'b1;
    end else if (mrow_pop_i && valid_q) begin
      row_q <= row_q + 4'd1;
      // Mask used up
      if (last_row) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (mask_load_i) begin
      mask_q <= mask_bits_i;
    end
  end

endmodule

// File: shuffle/shf_info_queue.sv
`timescale 1ns/1ps
`include "vlsu_defines.svh"

module shf_info_queue #(
  parameter int unsigned Depth = `VLSU_INFO_DEPTH
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    enq_i,
  input  vlsu_msg_pkg::shf_info_t enq_data_i,
  input  logic                    deq_i,
  input  logic                    upd_i,
  output logic                    full_o,
  output logic                    empty_o,
  output vlsu_msg_pkg::shf_info_t head_o
);

  localparam int unsigned PtrBits = $clog2(Depth);

  vlsu_msg_pkg::shf_info_t mem_q [Depth];

  // Pointer value plus wrap flag
  logic [PtrBits-1:0] wr_ptr_q;
  logic [PtrBits-1:0] rd_ptr_q;
  logic               wr_flag_q;
  logic               rd_flag_q;

  // Step {flag, value}, flag toggles on wrap
  function automatic logic [PtrBits:0] ptr_next(input logic flag, input logic [PtrBits-1:0] ptr);
    if (ptr == PtrBits'(Depth - 1)) begin
      return {!flag, {PtrBits{1'b0}}};
    end
    return {flag, ptr + 1'b1};
  endfunction

  assign empty_o = (wr_ptr_q == rd_ptr_q) && (wr_flag_q == rd_flag_q);
  assign full_o  = (wr_ptr_q == rd_ptr_q) && (wr_flag_q != rd_flag_q);
  assign head_o  = mem_q[rd_ptr_q];

  // --------------------
  // Pointers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q  <= '0;
      wr_flag_q <= 1'b0;
      rd_ptr_q  <= '0;
      rd_flag_q <= 1'b0;
    end else begin
      if (enq_i) begin
        {wr_flag_q, wr_ptr_q} <= ptr_next(wr_flag_q, wr_ptr_q);
      end
      if (deq_i) begin
        {rd_flag_q, rd_ptr_q} <= ptr_next(rd_flag_q, rd_ptr_q);
      end
    end
  end

  // --------------------
  // Storage
  // --------------------
  always_ff @(posedge clk_i) begin
    if (enq_i) begin
      mem_q[wr_ptr_q] <= enq_data_i;
    end
    // Head moves on to its next row in place
    if (upd_i) begin
      mem_q[rd_ptr_q].vaddr_set    <= head_o.vaddr_set + 1'b1;
      mem_q[rd_ptr_q].meta.row_cnt <= head_o.meta.row_cnt - 1'b1;
    end
  end

endmodule

// File: shuffle/shuffle_unit.sv
`timescale 1ns/1ps
`include "vlsu_defines.svh"

module shuffle_unit (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // Metadata
  input  logic                                          meta_valid_i,
  output logic                                          meta_ready_o,
  input  vlsu_msg_pkg::ld_meta_t                        meta_i,
  // Sequential row
  seq_row_if.consumer                                   row,
  // Mask strobes
  input  logic                                          mrow_valid_i,
  input  logic [`VLSU_ROW_BYTES-1:0]                    mrow_strb_i,
  output logic                                          mrow_pop_o,
  // Lanes
  output logic [`VLSU_NR_LANES-1:0]                     lane_valid_o,
  input  logic [`VLSU_NR_LANES-1:0]                     lane_ready_i,
  output vlsu_msg_pkg::lane_tx_t [`VLSU_NR_LANES-1:0]   lane_tx_o,
  // Completion
  output logic                                          done_valid_o,
  output logic [`VLSU_REQ_ID_BITS-1:0]                  done_id_o
);

  localparam int unsigned SetBits = `VLSU_SET_BITS;

  vlsu_msg_pkg::shf_info_t head;
  vlsu_msg_pkg::shf_info_t enq_info;
  logic                    q_full;
  logic                    q_empty;
  logic                    q_enq;
  logic                    q_deq;
  logic                    q_upd;

  logic                    row_ok;
  logic                    row_fire;

  // Lane buffers
  logic [`VLSU_NR_LANES-1:0]                     lane_valid_q;
  vlsu_msg_pkg::lane_tx_t [`VLSU_NR_LANES-1:0]   lane_q;
  vlsu_msg_pkg::lane_tx_t [`VLSU_NR_LANES-1:0]   shf_tx;

  // --------------------
  // Metadata queue
  // --------------------
  assign meta_ready_o = !q_full;
  assign q_enq        = meta_valid_i && !q_full;

  // Start at the first row of vd
  always_comb begin
    enq_info.meta      = meta_i;
    enq_info.vaddr_set = SetBits'(meta_i.vd * `VLSU_ROWS_PER_REG);
  end

  shf_info_queue #(
    .Depth(`VLSU_INFO_DEPTH)
  ) u_info_queue (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .enq_i      (q_enq),
    .enq_data_i (enq_info),
    .deq_i      (q_deq),
    .upd_i      (q_upd),
    .full_o     (q_full),
    .empty_o    (q_empty),
    .head_o     (head)
  );

  // --------------------
  // Row accept
  // --------------------
  // All lanes drained, metadata present, mask ready unless unmasked
  assign row_ok    = !(|lane_valid_q) && !q_empty && (head.meta.vm || mrow_valid_i);
  assign row.ready = row_ok;
  assign row_fire  = row.valid && row_ok;

  // Last row retires the entry, otherwise step to next set
  assign q_deq = row_fire && (head.meta.row_cnt == '0);
  assign q_upd = row_fire && (head.meta.row_cnt != '0);

  assign mrow_pop_o   = row_fire && !head.meta.vm;
  assign done_valid_o = q_deq;
  assign done_id_o    = head.meta.req_id;

  // --------------------
  // Shuffle
  // --------------------
  always_comb begin
    int unsigned sidx;
    for (int l = 0; l < `VLSU_NR_LANES; l++) begin
      shf_tx[l].req_id    = head.meta.req_id;
      shf_tx[l].vaddr_set = head.vaddr_set;
      for (int o = 0; o < `VLSU_LANE_BYTES; o++) begin
        sidx = vlsu_cfg_pkg::seq_byte_idx(l * `VLSU_LANE_BYTES + o, head.meta.ew);
        shf_tx[l].data[o*8 +: 8] = row.data[sidx*8 +: 8];
        // Mask strobe indexed by the same sequential byte
        shf_tx[l].be[o] = row.be[sidx] && (head.meta.vm || mrow_strb_i[sidx]);
      end
    end
  end

  // Lanes fill together, drain one by one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lane_valid_q <= '0;
    end else if (row_fire) begin
      lane_valid_q <= '1;
    end else begin
      lane_valid_q <= lane_valid_q & ~lane_ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (row_fire) begin
      lane_q <= shf_tx;
    end
  end

  assign lane_valid_o = lane_valid_q;
  assign lane_tx_o    = lane_q;

endmodule

// File: logic/vlsu_load_top.sv
`timescale 1ns/1ps
`include "vlsu_defines.svh"

module vlsu_load_top (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  // Memory beats
  input  logic                                                 beat_valid_i,
  output logic                                                 beat_ready_o,
  input  logic [`VLSU_BEAT_BYTES*8-1:0]                        beat_data_i,
  input  logic [`VLSU_BEAT_BYTES-1:0]                          beat_be_i,
  // Metadata
  input  logic                                                 meta_valid_i,
  output logic                                                 meta_ready_o,
  input  logic [`VLSU_REQ_ID_BITS-1:0]                         meta_req_id_i,
  input  vlsu_cfg_pkg::ld_mode_e                               meta_mode_i,
  input  vlsu_cfg_pkg::ew_e                                    meta_ew_i,
  input  logic [4:0]                                           meta_vd_i,
  input  logic                                                 meta_vm_i,
  input  logic [3:0]                                           meta_row_cnt_i,
  // Mask load
  input  logic                                                 mask_load_i,
  input  vlsu_cfg_pkg::ew_e                                    mask_ew_i,
  input  logic [63:0]                                          mask_bits_i,
  // Lanes
  output logic [`VLSU_NR_LANES-1:0]                            lane_valid_o,
  input  logic [`VLSU_NR_LANES-1:0]                            lane_ready_i,
  output logic [`VLSU_NR_LANES-1:0][`VLSU_REQ_ID_BITS-1:0]     lane_req_id_o,
  output logic [`VLSU_NR_LANES-1:0][`VLSU_SET_BITS-1:0]        lane_set_o,
  output logic [`VLSU_NR_LANES-1:0][`VLSU_LANE_BYTES*8-1:0]    lane_data_o,
  output logic [`VLSU_NR_LANES-1:0][`VLSU_LANE_BYTES-1:0]      lane_be_o,
  // Completion
  output logic                                                 done_valid_o,
  output logic [`VLSU_REQ_ID_BITS-1:0]                         done_id_o
);

  seq_row_if row_if ();

  vlsu_msg_pkg::ld_meta_t                        meta;
  vlsu_msg_pkg::lane_tx_t [`VLSU_NR_LANES-1:0]   lane_tx;
  logic                                          mrow_valid;
  logic [`VLSU_ROW_BYTES-1:0]                    mrow_strb;
  logic                                          mrow_pop;

  // Flat metadata fields into struct
  assign meta.req_id  = meta_req_id_i;
  assign meta.mode    = meta_mode_i;
  assign meta.ew      = meta_ew_i;
  assign meta.vd      = meta_vd_i;
  assign meta.vm      = meta_vm_i;
  assign meta.row_cnt = meta_row_cnt_i;

  seq_load u_seq_load (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .beat_valid_i (beat_valid_i),
    .beat_ready_o (beat_ready_o),
    .beat_data_i  (beat_data_i),
    .beat_be_i    (beat_be_i),
    .row          (row_if)
  );

  mask_unit u_mask_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mask_load_i  (mask_load_i),
    .mask_ew_i    (mask_ew_i),
    .mask_bits_i  (mask_bits_i),
    .mrow_pop_i   (mrow_pop),
    .mrow_valid_o (mrow_valid),
    .mrow_strb_o  (mrow_strb)
  );

  shuffle_unit u_shuffle_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .meta_valid_i (meta_valid_i),
    .meta_ready_o (meta_ready_o),
    .meta_i       (meta),
    .row          (row_if),
    .mrow_valid_i (mrow_valid),
    .mrow_strb_i  (mrow_strb),
    .mrow_pop_o   (mrow_pop),
    .lane_valid_o (lane_valid_o),
    .lane_ready_i (lane_ready_i),
    .lane_tx_o    (lane_tx),
    .done_valid_o (done_valid_o),
    .done_id_o    (done_id_o)
  );

  // Lane structs onto flat ports
  for (genvar l = 0; l < `VLSU_NR_LANES; l++) begin : g_lane_out
    assign lane_req_id_o[l] = lane_tx[l].req_id;
    assign lane_set_o[l]    = lane_tx[l].vaddr_set;
    assign lane_data_o[l]   = lane_tx[l].data;
    assign lane_be_o[l]     = lane_tx[l].be;
  end

endmodule

// File: bench/vlsu_assertions.sv
`timescale 1ns/1ps
`include "vlsu_defines.svh"

module vlsu_assertions (
  input logic                                         clk_i,
  input logic                                         rst_ni,
  input logic [`VLSU_NR_LANES-1:0]                    lane_valid_o,
  input logic [`VLSU_NR_LANES-1:0]                    lane_ready_i,
  input vlsu_msg_pkg::lane_tx_t [`VLSU_NR_LANES-1:0]  lane_tx_o,
  input logic                                         row_fire,
  input logic                                         q_enq,
  input logic                                         q_deq,
  input vlsu_msg_pkg::shf_info_t                      head
);

  // Entries held, counted from the queue strobes
  logic [3:0] occ_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_q + 4'(q_enq) - 4'(q_deq);
    end
  end

  for (genvar l = 0; l < `VLSU_NR_LANES; l++) begin : g_lane
    // Valid and payload hold until this lane's ready
    a_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      lane_valid_o[l] && !lane_ready_i[l] |=> lane_valid_o[l] && $stable(lane_tx_o[l]))
      else $error("lane %0d dropped valid or payload before ready", l);
  end

  // Last set of the instruction still inside the register file
  a_set_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    row_fire |-> (8'(head.vaddr_set) + 8'(head.meta.row_cnt) < 8'd128))
    else $error("set address runs past the register file");

  // Row only with an instruction at the head
  a_row_needs_info: assert property (@(posedge clk_i) disable iff (!rst_ni)
    row_fire |-> (occ_q != '0))
    else $error("row accepted with empty metadata queue");

endmodule

bind shuffle_unit vlsu_assertions u_vlsu_assertions (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .lane_valid_o (lane_valid_o),
  .lane_ready_i (lane_ready_i),
  .lane_tx_o    (lane_tx_o),
  .row_fire     (row_fire),
  .q_enq        (q_enq),
  .q_deq        (q_deq),
  .head         (head)
);

// File: bench/tb_vlsu_load.sv
`timescale 1ns/1ps
`include "vlsu_defines.svh"

module tb_vlsu_load;

  localparam int NrLanes = `VLSU_NR_LANES;
  localparam int SetBits = `VLSU_SET_BITS;
  localparam int TxBits  = `VLSU_REQ_ID_BITS + SetBits + 32 + 4;
  // 5 tests, 13 rows, a few dozen cycles each plus reset, wide margin
  localparam int TimeoutCycles = 4000;

  typedef logic [TxBits-1:0] tx_t;

  logic clk_i;
  logic rst_ni;
  logic beat_valid_i;
  logic beat_ready_o;
  logic [63:0] beat_data_i;
  logic [7:0] beat_be_i;
  logic meta_valid_i;
  logic meta_ready_o;
  logic [2:0] meta_req_id_i;
  vlsu_cfg_pkg::ld_mode_e meta_mode_i;
  vlsu_cfg_pkg::ew_e meta_ew_i;
  logic [4:0] meta_vd_i;
  logic meta_vm_i;
  logic [3:0] meta_row_cnt_i;
  logic mask_load_i;
  vlsu_cfg_pkg::ew_e mask_ew_i;
  logic [63:0] mask_bits_i;
  logic [NrLanes-1:0] lane_valid_o;
  logic [NrLanes-1:0] lane_ready_i;
  logic [NrLanes-1:0][2:0] lane_req_id_o;
  logic [NrLanes-1:0][SetBits-1:0] lane_set_o;
  logic [NrLanes-1:0][31:0] lane_data_o;
  logic [NrLanes-1:0][3:0] lane_be_o;
  logic done_valid_o;
  logic [2:0] done_id_o;

  // Scoreboard, one queue per lane plus completions
  tx_t exp_q [NrLanes][$];
  tx_t got_q [NrLanes][$];
  logic [2:0] exp_done_q [$];
  logic [2:0] got_done_q [$];

  logic [31:0] lfsr_q;
  int cycles;
  int err_cnt;
  int test_cnt;
  int fail_cnt;

  vlsu_load_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // --------------------
  // Stimulus helpers
  // --------------------
  // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v[i] = fb;
    end
    return v;
  endfunction

  task automatic send_meta(input logic [2:0] id, input vlsu_cfg_pkg::ew_e ew,
                           input logic [4:0] vd, input logic vm, input logic [3:0] row_cnt);
    logic ok;
    meta_valid_i   = 1'b1;
    meta_req_id_i  = id;
    meta_mode_i    = vlsu_cfg_pkg::UNIT;
    meta_ew_i      = ew;
    meta_vd_i      = vd;
    meta_vm_i      = vm;
    meta_row_cnt_i = row_cnt;
    do begin
      ok = meta_ready_o;
      @(posedge clk_i);
      #1;
    end while (!ok);
    meta_valid_i = 1'b0;
    exp_done_q.push_back(id);
  endtask

  task automatic load_mask(input vlsu_cfg_pkg::ew_e ew, input logic [63:0] bits);
    mask_ew_i   = ew;
    mask_bits_i = bits;
    mask_load_i = 1'b1;
    @(posedge clk_i);
    #1;
    mask_load_i = 1'b0;
  endtask

  task automatic send_beat(input logic [63:0] data, input logic [7:0] be);
    logic ok;
    beat_valid_i = 1'b1;
    beat_data_i  = data;
    beat_be_i    = be;
    // Ready is registered, stable until the next edge
    do begin
      ok = beat_ready_o;
      @(posedge clk_i);
      #1;
    end while (!ok);
    beat_valid_i = 1'b0;
  endtask

  // Random row r of an instruction, expected lane writes from the shuffle rule
  task automatic send_row(input logic [2:0] id, input vlsu_cfg_pkg::ew_e ew, input logic [4:0] vd,
                          input logic vm, input int r, input logic [63:0] mask,
                          input logic [15:0] row_be = 16'hffff);
    logic [127:0] row_data;
    logic [31:0] exp_data [NrLanes];
    logic [3:0] exp_be [NrLanes];
    int eb;
    int e;
    int l;
    int pos;
    row_data[63:0]   = take_bits(64);
    row_data[127:64] = take_bits(64);
    eb = 1 << int'(ew);
    for (int b = 0; b < `VLSU_ROW_BYTES; b++) begin
      e   = b / eb;
      l   = e % NrLanes;
      // Slot e div 4, then byte within element
      pos = (e / NrLanes) * eb + b % eb;
      exp_data[l][pos*8 +: 8] = row_data[b*8 +: 8];
      exp_be[l][pos] = row_be[b] && (vm || mask[r * (`VLSU_ROW_BYTES / eb) + e]);
    end
    for (int k = 0; k < NrLanes; k++) begin
      exp_q[k].push_back({id, SetBits'(vd * `VLSU_ROWS_PER_REG + r), exp_data[k], exp_be[k]});
    end
    send_beat(row_data[63:0], row_be[7:0]);
    send_beat(row_data[127:64], row_be[15:8]);
  endtask

  // --------------------
  // Scoreboard
  // --------------------
  function automatic logic all_seen();
    logic seen;
    seen = (got_done_q.size() >= exp_done_q.size());
    for (int l = 0; l < NrLanes; l++) begin
      seen = seen && (got_q[l].size() >= exp_q[l].size());
    end
    return seen;
  endfunction

  task automatic check_results(input string name, input int errs_at_start);
    tx_t exp_tx;
    tx_t got_tx;
    logic [2:0] exp_id;
    logic [2:0] got_id;
    while (!all_seen()) begin
      @(posedge clk_i);
      #1;
    end
    for (int l = 0; l < NrLanes; l++) begin
      while (exp_q[l].size() > 0) begin
        exp_tx = exp_q[l].pop_front();
        got_tx = got_q[l].pop_front();
        if (got_tx !== exp_tx) begin
          $display("** Error %s lane %0d: expected %h, actual %h", name, l, exp_tx, got_tx);
          err_cnt++;
        end
      end
    end
    while (exp_done_q.size() > 0) begin
      exp_id = exp_done_q.pop_front();
      got_id = got_done_q.pop_front();
      if (got_id !== exp_id) begin
        $display("** Error %s done id: expected %0d, actual %0d", name, exp_id, got_id);
        err_cnt++;
      end
    end
    test_cnt++;
    if (err_cnt == errs_at_start) begin
      $display("Test %s: passed", name);
    end else begin
      fail_cnt++;
      $display("Test %s: failed with %0d errors", name, err_cnt - errs_at_start);
    end
  endtask

  // Lane and done handshakes, sampled mid-cycle
  initial begin
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk_i);
      #3;
      cycles++;
      for (int l = 0; l < NrLanes; l++) begin
        if (rst_ni && lane_valid_o[l] && lane_ready_i[l]) begin
          got_q[l].push_back({lane_req_id_o[l], lane_set_o[l], lane_data_o[l], lane_be_o[l]});
        end
      end
      if (rst_ni && done_valid_o) begin
        got_done_q.push_back(done_id_o);
      end
    end
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("** FAIL **");
    $finish;
  end

  // --------------------
  // Directed tests
  // --------------------
  task automatic test_ew8_unmasked();
    int start;
    start = err_cnt;
    send_meta(3'd1, vlsu_cfg_pkg::EW8, 5'd2, 1'b1, 4'd0);
    send_row(3'd1, vlsu_cfg_pkg::EW8, 5'd2, 1'b1, 0, '0);
    check_results("ew8_unmasked", start);
  endtask

  task automatic test_ew16_ew32_rows();
    int start;
    start = err_cnt;
    send_meta(3'd2, vlsu_cfg_pkg::EW16, 5'd5, 1'b1, 4'd1);
    send_row(3'd2, vlsu_cfg_pkg::EW16, 5'd5, 1'b1, 0, '0);
    send_row(3'd2, vlsu_cfg_pkg::EW16, 5'd5, 1'b1, 1, '0);
    send_meta(3'd3, vlsu_cfg_pkg::EW32, 5'd9, 1'b1, 4'd1);
    // Partial memory byte enables follow the same shuffle
    send_row(3'd3, vlsu_cfg_pkg::EW32, 5'd9, 1'b1, 0, '0, 16'(take_bits(16)));
    send_row(3'd3, vlsu_cfg_pkg::EW32, 5'd9, 1'b1, 1, '0, 16'(take_bits(16)));
    check_results("ew16_ew32_rows", start);
  endtask

  task automatic test_masked_ew16();
    int start;
    logic [63:0] mask;
    start = err_cnt;
    mask = take_bits(64);
    send_meta(3'd4, vlsu_cfg_pkg::EW16, 5'd12, 1'b0, 4'd1);
    load_mask(vlsu_cfg_pkg::EW16, mask);
    send_row(3'd4, vlsu_cfg_pkg::EW16, 5'd12, 1'b0, 0, mask);
    send_row(3'd4, vlsu_cfg_pkg::EW16, 5'd12, 1'b0, 1, mask);
    check_results("masked_ew16", start);
  endtask

  task automatic test_lane_backpressure();
    int start;
    start = err_cnt;
    // Lane 2 stalled, the others free
    lane_ready_i = 4'b1011;
    send_meta(3'd5, vlsu_cfg_pkg::EW32, 5'd20, 1'b1, 4'd1);
    send_row(3'd5, vlsu_cfg_pkg::EW32, 5'd20, 1'b1, 0, '0);
    send_row(3'd5, vlsu_cfg_pkg::EW32, 5'd20, 1'b1, 1, '0);
    repeat (6) begin
      @(posedge clk_i);
      #1;
    end
    if (lane_valid_o !== 4'b0100) begin
      $display("** Error lane_backpressure lane valids: expected 0100, actual %b", lane_valid_o);
      err_cnt++;
    end
    if (got_q[0].size() != 1) begin
      $display("** Error lane_backpressure lane 0 writes: expected 1, actual %0d",
               got_q[0].size());
      err_cnt++;
    end
    lane_ready_i = 4'b1111;
    check_results("lane_backpressure", start);
  endtask

  task automatic test_queue_fill();
    int start;
    start = err_cnt;
    send_meta(3'd6, vlsu_cfg_pkg::EW8, 5'd24, 1'b1, 4'd0);
    send_meta(3'd7, vlsu_cfg_pkg::EW8, 5'd25, 1'b1, 4'd0);
    send_meta(3'd0, vlsu_cfg_pkg::EW8, 5'd26, 1'b1, 4'd0);
    send_meta(3'd1, vlsu_cfg_pkg::EW8, 5'd27, 1'b1, 4'd0);
    if (meta_ready_o !== 1'b0) begin
      $display("** Error queue_fill meta_ready: expected 0, actual %b", meta_ready_o);
      err_cnt++;
    end
    send_row(3'd6, vlsu_cfg_pkg::EW8, 5'd24, 1'b1, 0, '0);
    send_row(3'd7, vlsu_cfg_pkg::EW8, 5'd25, 1'b1, 0, '0);
    send_row(3'd0, vlsu_cfg_pkg::EW8, 5'd26, 1'b1, 0, '0);
    send_row(3'd1, vlsu_cfg_pkg::EW8, 5'd27, 1'b1, 0, '0);
    check_results("queue_fill", start);
  endtask

  initial begin
    lfsr_q         = 32'h98e7;
    err_cnt        = 0;
    test_cnt       = 0;
    fail_cnt       = 0;
    rst_ni         = 1'b0;
    beat_valid_i   = 1'b0;
    beat_data_i    = '0;
    beat_be_i      = '0;
    meta_valid_i   = 1'b0;
    meta_req_id_i  = '0;
    meta_mode_i    = vlsu_cfg_pkg::UNIT;
    meta_ew_i      = vlsu_cfg_pkg::EW8;
    meta_vd_i      = '0;
    meta_vm_i      = 1'b0;
    meta_row_cnt_i = '0;
    mask_load_i    = 1'b0;
    mask_ew_i      = vlsu_cfg_pkg::EW8;
    mask_bits_i    = '0;
    lane_ready_i   = '1;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;
    test_ew8_unmasked();
    test_ew16_ew32_rows();
    test_masked_ew16();
    test_lane_backpressure();
    test_queue_fill();
    $display("Tests run %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+common
common/vlsu_cfg_pkg.sv
common/vlsu_msg_pkg.sv
common/seq_row_if.sv
seq_load/seq_load.sv
logic/mask_unit.sv
shuffle/shf_info_queue.sv
shuffle/shuffle_unit.sv
logic/vlsu_load_top.sv
bench/vlsu_assertions.sv
bench/tb_vlsu_load.sv

// File: Makefile
TOP := tb_vlsu_load

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q '^\*\* PASS \*\*$$'

clean:
	rm -rf obj_dir
